// ==== src/apu_pkg.sv ====
`default_nettype none

package apu_pkg;

  // Register slots of the CPU-side port.
  typedef enum logic [4:0] {
    PULSE0_CTL   = 5'd0,
    PULSE0_SWEEP = 5'd1,
    PULSE0_LO    = 5'd2,
    PULSE0_HI    = 5'd3,
    PULSE1_CTL   = 5'd4,
    PULSE1_SWEEP = 5'd5,
    PULSE1_LO    = 5'd6,
    PULSE1_HI    = 5'd7,
    TRI_LINEAR   = 5'd8,
    TRI_LO       = 5'd10,
    TRI_HI       = 5'd11,
    STATUS       = 5'd21,
    FRAME_CTL    = 5'd23
  } reg_addr_e;

  typedef enum logic [1:0] {
    STEP0,
    STEP1,
    STEP2,
    STEP3
  } seq_step_e;

  // Laid out in register order, so four bytes map straight onto it.
  typedef struct packed {
    logic [4:0]  length_index;  // Slot 3/7, upper bits.
    logic [10:0] timer_period;  // Slot 3/7 low bits and slot 2/6.
    logic [7:0]  sweep;         // Slot 1/5, no sweep unit behind it.
    logic [1:0]  duty;
    logic        length_halt;   // Also loops the envelope.
    logic        const_vol;
    logic [3:0]  vol;
  } pulse_regs_t;

  typedef struct packed {
    logic [4:0]  length_index;
    logic [10:0] timer_period;
    logic        length_halt;   // Doubles as the linear counter control flag.
    logic [6:0]  linear_load_data;
  } triangle_regs_t;

  typedef struct packed {
    logic triangle_en;
    logic pulse1_en;
    logic pulse0_en;
  } status_t;

  typedef struct packed {
    logic mode;
    logic inhibit_interrupt;
  } frame_ctl_t;

  localparam logic [15:0] PULSE_WEIGHT    = 16'd256;
  localparam logic [15:0] TRIANGLE_WEIGHT = 16'd192;

  // Length counter load values.
  function automatic logic [7:0] length_lookup(input logic [4:0] index);
    logic [7:0] count;
    case (index)
      5'd0:    count = 8'd10;
      5'd1:    count = 8'd254;
      5'd2:    count = 8'd20;
      5'd3:    count = 8'd2;
      5'd4:    count = 8'd40;
      5'd5:    count = 8'd4;
      5'd6:    count = 8'd80;
      5'd7:    count = 8'd6;
      5'd8:    count = 8'd160;
      5'd9:    count = 8'd8;
      5'd10:   count = 8'd60;
      5'd11:   count = 8'd10;
      5'd12:   count = 8'd14;
      5'd13:   count = 8'd12;
      5'd14:   count = 8'd26;
      5'd15:   count = 8'd14;
      5'd16:   count = 8'd12;
      5'd17:   count = 8'd16;
      5'd18:   count = 8'd24;
      5'd19:   count = 8'd18;
      5'd20:   count = 8'd48;
      5'd21:   count = 8'd20;
      5'd22:   count = 8'd96;
      5'd23:   count = 8'd22;
      5'd24:   count = 8'd192;
      5'd25:   count = 8'd24;
      5'd26:   count = 8'd72;
      5'd27:   count = 8'd26;
      5'd28:   count = 8'd16;
      5'd29:   count = 8'd28;
      5'd30:   count = 8'd32;
      default: count = 8'd30;
    endcase
    return count;
  endfunction

  // Next value of a channel length counter, shared by pulse and triangle.
  function automatic logic [7:0] length_next(
    input logic [7:0] count,
    input logic       enable,
    input logic       load,
    input logic       tick,
    input logic       halt,
    input logic [4:0] index
  );
    logic [7:0] result;
    result = count;
    if (!enable)
      result = 8'd0;  // A cleared status bit wins over everything.
    else if (load)
      result = length_lookup(index);
    else if (tick && !halt && (count != 8'd0))
      result = count - 8'd1;
    return result;
  endfunction

endpackage

`default_nettype wire

// ==== src/apu_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_registers (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       reg_addr,
  input  logic [7:0]       reg_data,
  input  logic             reg_en,
  input  logic             reg_we,
  output logic [23:0][7:0] reg_array,
  output logic [23:0]      reg_updates
);

  logic wr;

  // Slots 24 to 31 do not exist and are dropped.
  assign wr = reg_en && reg_we && (reg_addr < 5'd24);

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_array   <= '0;
      reg_updates <= '0;
    end else begin
      reg_updates <= '0;  // Strobes last one clock.
      if (wr) begin
        reg_array[reg_addr]   <= reg_data;
        reg_updates[reg_addr] <= 1'b1;  // Seen together with the new byte.
      end
    end
  end

  // One write per clock, so never more than one strobe.
  a_updates_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0(reg_updates)
  );

endmodule

`default_nettype wire

// ==== src/frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer #(
  parameter logic [15:0] STEP_PERIOD = 16'd3729
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               apu_clk_en,
  input  apu_pkg::frame_ctl_t ctl,
  input  logic               load,
  output logic               quarter_clk_en,
  output logic               half_clk_en,
  output logic               interrupt
);

  logic [15:0]        divider;
  apu_pkg::seq_step_e step;
  logic               step_done;
  logic               half_step;

  assign step_done = (divider == STEP_PERIOD - 16'd1);
  assign half_step = (step == apu_pkg::STEP1) || (step == apu_pkg::STEP3);

  always_ff @(posedge clk) begin
    if (rst) begin
      divider        <= '0;
      step           <= apu_pkg::STEP0;
      quarter_clk_en <= 1'b0;
      half_clk_en    <= 1'b0;
      interrupt      <= 1'b0;
    end else begin
      quarter_clk_en <= 1'b0;
      half_clk_en    <= 1'b0;
      if (load) begin
        // Restart the sequence from the top.
        divider <= '0;
        step    <= apu_pkg::STEP0;
        if (ctl.inhibit_interrupt)
          interrupt <= 1'b0;
      end else if (apu_clk_en) begin
        if (step_done) begin
          divider        <= '0;
          step           <= apu_pkg::seq_step_e'(step + 2'd1);
          quarter_clk_en <= 1'b1;
          half_clk_en    <= half_step;
          // Only the 4-step mode raises the IRQ.
          if ((step == apu_pkg::STEP3) && !ctl.inhibit_interrupt && !ctl.mode)
            interrupt <= 1'b1;
        end else begin
          divider <= divider + 16'd1;
        end
      end
    end
  end

  a_half_with_quarter: assert property (
    @(posedge clk) disable iff (rst) half_clk_en |-> quarter_clk_en
  );

endmodule

`default_nettype wire

// ==== src/pulse_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module pulse_channel (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 apu_clk_en,
  input  logic                 quarter_clk_en,
  input  logic                 half_clk_en,
  input  logic                 enable,
  input  apu_pkg::pulse_regs_t regs,
  input  logic                 env_load,
  input  logic                 length_load,
  output logic [3:0]           out
);

  logic [10:0] timer;
  logic [2:0]  duty_step;
  logic [7:0]  duty_pattern;
  logic        env_start;
  logic [3:0]  env_div;
  logic [3:0]  env_decay;
  logic [3:0]  volume;
  logic [7:0]  length_count;
  logic        audible;

  // Waveforms for 12.5, 25, 50 and inverted 25 percent.
  always_comb begin
    case (regs.duty)
      2'd0:    duty_pattern = 8'b0100_0000;
      2'd1:    duty_pattern = 8'b0110_0000;
      2'd2:    duty_pattern = 8'b0111_1000;
      default: duty_pattern = 8'b1001_1111;
    endcase
  end

  // Timer and duty position.
  always_ff @(posedge clk) begin
    if (rst) begin
      timer     <= '0;
      duty_step <= '0;
    end else begin
      if (apu_clk_en) begin
        if (timer == 11'd0) begin
          timer     <= regs.timer_period;
          duty_step <= duty_step + 3'd1;
        end else begin
          timer <= timer - 11'd1;
        end
      end
      if (length_load)
        duty_step <= 3'd0;  // New note starts at the top of the waveform.
    end
  end

  // Envelope: divider clocks a 15-to-0 decay.
  always_ff @(posedge clk) begin
    if (rst) begin
      env_start <= 1'b0;
      env_div   <= '0;
      env_decay <= '0;
    end else begin
      if (quarter_clk_en) begin
        if (env_start) begin
          env_start <= 1'b0;
          env_div   <= regs.vol;
          env_decay <= 4'd15;
        end else if (env_div == 4'd0) begin
          env_div <= regs.vol;
          if (env_decay != 4'd0)
            env_decay <= env_decay - 4'd1;
          else if (regs.length_halt)
            env_decay <= 4'd15;  // Looping envelope.
        end else begin
          env_div <= env_div - 4'd1;
        end
      end
      if (env_load)
        env_start <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      length_count <= '0;
    else
      length_count <= apu_pkg::length_next(length_count, enable, length_load,
                                           half_clk_en, regs.length_halt,
                                           regs.length_index);
  end

  assign volume  = regs.const_vol ? regs.vol : env_decay;
  assign audible = duty_pattern[3'd7 - duty_step] && (length_count != 8'd0) &&
                   (regs.timer_period >= 11'd8) && enable;  // Short periods are muted.
  assign out     = audible ? volume : 4'd0;

  // Disabled means silent now and an empty length counter next clock.
  a_silent_when_disabled: assert property (
    @(posedge clk) disable iff (rst)
    !enable |-> (out == 4'd0) ##1 (length_count == 8'd0)
  );

endmodule

`default_nettype wire

// ==== src/triangle_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module triangle_channel (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cpu_clk_en,
  input  logic                    quarter_clk_en,
  input  logic                    half_clk_en,
  input  logic                    enable,
  input  apu_pkg::triangle_regs_t regs,
  input  logic                    load,
  output logic [3:0]              out
);

  logic [10:0] timer;
  logic [4:0]  seq_step;
  logic [6:0]  linear_count;
  logic        linear_reload;
  logic [7:0]  length_count;
  logic        running;

  assign running = (linear_count != 7'd0) && (length_count != 8'd0);

  // Timer runs at CPU rate, twice the pulse rate.
  always_ff @(posedge clk) begin
    if (rst) begin
      timer    <= '0;
      seq_step <= '0;
    end else if (cpu_clk_en) begin
      if (timer == 11'd0) begin
        timer <= regs.timer_period;
        if (running)
          seq_step <= seq_step + 5'd1;
      end else begin
        timer <= timer - 11'd1;
      end
    end
  end

  // Linear counter.
  always_ff @(posedge clk) begin
    if (rst) begin
      linear_count  <= '0;
      linear_reload <= 1'b0;
    end else begin
      if (quarter_clk_en) begin
        if (linear_reload)
          linear_count <= regs.linear_load_data;
        else if (linear_count != 7'd0)
          linear_count <= linear_count - 7'd1;
        if (!regs.length_halt)
          linear_reload <= 1'b0;  // Halt keeps reloading every quarter.
      end
      if (load)
        linear_reload <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      length_count <= '0;
    else
      length_count <= apu_pkg::length_next(length_count, enable, load,
                                           half_clk_en, regs.length_halt,
                                           regs.length_index);
  end

  // Ramp up over the low half, down over the high half.
  // The sequencer just stops, so the last level is held.
  assign out = seq_step[4] ? ~seq_step[3:0] : seq_step[3:0];

endmodule

`default_nettype wire

// ==== src/mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mixer (
  input  logic        clk,
  input  logic        rst,
  input  logic [3:0]  pulse0,
  input  logic [3:0]  pulse1,
  input  logic [3:0]  triangle,
  output logic [15:0] out
);

  logic [4:0]  pulse_sum;
  logic [17:0] mix_sum;

  assign pulse_sum = {1'b0, pulse0} + {1'b0, pulse1};
  assign mix_sum   = 18'(pulse_sum) * 18'(apu_pkg::PULSE_WEIGHT) +
                     18'(triangle) * 18'(apu_pkg::TRIANGLE_WEIGHT);

  always_ff @(posedge clk) begin
    if (rst)
      out <= '0;
    else if (mix_sum > 18'h0_FFFF)
      out <= 16'hFFFF;  // Clip.
    else
      out <= mix_sum[15:0];
  end

endmodule

`default_nettype wire

// ==== src/apu.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu #(
  parameter logic [15:0] STEP_PERIOD = 16'd3729
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        cpu_clk_en,
  input  logic        apu_clk_en,
  input  logic [4:0]  reg_addr,
  input  logic [7:0]  reg_data,
  input  logic        reg_en,
  input  logic        reg_we,
  output logic        irq_l,
  output logic [15:0] audio_out
);

  logic [23:0][7:0] reg_array;
  logic [23:0]      reg_updates;

  apu_pkg::pulse_regs_t    pulse0_regs, pulse1_regs;
  apu_pkg::triangle_regs_t triangle_regs;
  apu_pkg::status_t        status;
  apu_pkg::frame_ctl_t     frame_ctl;

  logic       quarter_clk_en, half_clk_en;
  logic       frame_interrupt;
  logic [3:0] pulse0_out, pulse1_out, triangle_out;

  apu_registers mm_reg (
    .clk, .rst, .reg_addr, .reg_data, .reg_en, .reg_we,
    .reg_array, .reg_updates);

  // Register bytes viewed as channel fields.
  assign pulse0_regs   = reg_array[apu_pkg::PULSE0_HI:apu_pkg::PULSE0_CTL];
  assign pulse1_regs   = reg_array[apu_pkg::PULSE1_HI:apu_pkg::PULSE1_CTL];
  assign triangle_regs = {reg_array[apu_pkg::TRI_HI], reg_array[apu_pkg::TRI_LO],
                          reg_array[apu_pkg::TRI_LINEAR]};  // Slot 9 is unused.
  assign status        = reg_array[apu_pkg::STATUS][2:0];
  assign frame_ctl     = reg_array[apu_pkg::FRAME_CTL][7:6];

  frame_sequencer #(.STEP_PERIOD(STEP_PERIOD)) fs (
    .clk, .rst, .apu_clk_en, .ctl(frame_ctl),
    .load(reg_updates[apu_pkg::FRAME_CTL]),
    .quarter_clk_en, .half_clk_en, .interrupt(frame_interrupt));

  pulse_channel pulse0_channel (
    .clk, .rst, .apu_clk_en, .quarter_clk_en, .half_clk_en,
    .enable(status.pulse0_en), .regs(pulse0_regs),
    .env_load(reg_updates[apu_pkg::PULSE0_CTL]),
    .length_load(reg_updates[apu_pkg::PULSE0_HI]),
    .out(pulse0_out));

  pulse_channel pulse1_channel (
    .clk, .rst, .apu_clk_en, .quarter_clk_en, .half_clk_en,
    .enable(status.pulse1_en), .regs(pulse1_regs),
    .env_load(reg_updates[apu_pkg::PULSE1_CTL]),
    .length_load(reg_updates[apu_pkg::PULSE1_HI]),
    .out(pulse1_out));

  triangle_channel tc (
    .clk, .rst, .cpu_clk_en, .quarter_clk_en, .half_clk_en,
    .enable(status.triangle_en), .regs(triangle_regs),
    .load(reg_updates[apu_pkg::TRI_HI]),
    .out(triangle_out));

  mixer linear_mixer (
    .clk, .rst, .pulse0(pulse0_out), .pulse1(pulse1_out),
    .triangle(triangle_out), .out(audio_out));

  assign irq_l = ~frame_interrupt;  // Active-low IRQ line.

endmodule

`default_nettype wire

// ==== tests/apu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_tb;

  localparam int STEP_PERIOD    = 24;
  localparam int HALF_CYCLES    = 4 * STEP_PERIOD;  // Two steps, APU enable every other clock.
  localparam int TIMEOUT_CYCLES = 40000;

  localparam logic [15:0] PULSE_STEP = 16'd256;
  localparam logic [15:0] TRI_STEP   = 16'd192;

  // Length counter load values by index.
  localparam logic [7:0] LENGTH_TABLE [32] = '{
    8'd10,  8'd254, 8'd20, 8'd2,  8'd40, 8'd4,  8'd80, 8'd6,
    8'd160, 8'd8,   8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
    8'd12,  8'd16,  8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
    8'd192, 8'd24,  8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
  };

  // Test sections.
  localparam int S_NONE     = 0;
  localparam int S_RESET    = 1;
  localparam int S_DISABLED = 2;
  localparam int S_TONE     = 3;
  localparam int S_SHORT    = 4;
  localparam int S_TRIANGLE = 5;
  localparam int S_IRQ      = 6;
  localparam int S_IRQ_OFF  = 7;
  localparam int S_LENGTH   = 8;
  localparam int S_EXPIRED  = 9;
  localparam int S_RETONE   = 10;
  localparam int S_CLEARED  = 11;
  localparam int S_DONE     = 12;

  logic        clk;
  logic        rst;
  logic        cpu_clk_en;
  logic        apu_clk_en = 1'b0;
  logic [4:0]  reg_addr;
  logic [7:0]  reg_data;
  logic        reg_en;
  logic        reg_we;
  logic        irq_l;
  logic [15:0] audio_out;

  int          section;
  int          monitored_section = -1;
  int          cycle_count = 0;
  logic [15:0] tone_level;        // Expected pulse0 level on audio_out.
  logic        seen_zero;
  logic        seen_level;
  logic [15:0] seen_levels;       // One bit per triangle level.
  logic [15:0] audio_step;

  apu #(.STEP_PERIOD(16'(STEP_PERIOD))) UUT (
    .clk, .rst, .cpu_clk_en, .apu_clk_en, .reg_addr, .reg_data,
    .reg_en, .reg_we, .irq_l, .audio_out);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) apu_clk_en <= ~apu_clk_en;  // Half the CPU rate.

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Run hit the limit of %0d cycles before finishing", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input int got, input string want);
    $display("error at %0t: %s = %0d, expected %s", $time, name, got, want);
    abort_run();
  endtask

  assign audio_step = audio_out / TRI_STEP;

  // Collects which levels showed up in the current section.
  always @(posedge clk) begin
    if (section != monitored_section) begin
      monitored_section <= section;
      seen_zero         <= 1'b0;
      seen_level        <= 1'b0;
      seen_levels       <= '0;
    end else begin
      if (audio_out == 16'd0)
        seen_zero <= 1'b1;
      if (audio_out == tone_level)
        seen_level <= 1'b1;
      if (((audio_out % TRI_STEP) == 16'd0) && (audio_out <= 16'd15 * TRI_STEP))
        seen_levels[audio_step[3:0]] <= 1'b1;
    end
  end

  a_irq_idle: assert property (@(posedge clk) disable iff (rst)
    (section == S_RESET || section == S_IRQ_OFF) |-> irq_l)
    else report_mismatch("irq_l", int'($sampled(irq_l)), "1");

  a_silent: assert property (@(posedge clk) disable iff (rst)
    (section == S_RESET || section == S_DISABLED || section == S_SHORT ||
     section == S_EXPIRED || section == S_CLEARED) |-> (audio_out == 16'd0))
    else report_mismatch("audio_out", int'($sampled(audio_out)), "0");

  a_tone_levels: assert property (@(posedge clk) disable iff (rst)
    (section == S_TONE || section == S_LENGTH || section == S_RETONE) |->
    (audio_out == 16'd0 || audio_out == tone_level))
    else report_mismatch("audio_out", int'($sampled(audio_out)),
                         $sformatf("0 or %0d", $sampled(tone_level)));

  a_triangle_levels: assert property (@(posedge clk) disable iff (rst)
    (section == S_TRIANGLE) |->
    ((audio_out % TRI_STEP) == 16'd0) && (audio_out <= 16'd15 * TRI_STEP))
    else report_mismatch("audio_out", int'($sampled(audio_out)),
                         "a multiple of 192 up to 2880");

  // Called on a rising edge, returns on the edge where the DUT takes the write.
  task automatic write_reg(input logic [4:0] addr, input logic [7:0] data);
    reg_addr <= addr;
    reg_data <= data;
    reg_en   <= 1'b1;
    reg_we   <= 1'b1;
    @(posedge clk);
    reg_en <= 1'b0;
    reg_we <= 1'b0;
  endtask

  // Constant-volume setup of one pulse channel, the HI byte loads the length.
  task automatic write_pulse(input logic [4:0] base, input logic [1:0] duty,
                             input logic halt, input logic [3:0] vol,
                             input logic [7:0] period, input logic [4:0] length_index);
    write_reg(base, {duty, halt, 1'b1, vol});
    write_reg(base + 5'd2, period);
    write_reg(base + 5'd3, {length_index, 3'b000});
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) @(posedge clk);
  endtask

  function automatic logic goal_reached();
    case (section)
      S_TONE:     return seen_zero && seen_level;
      S_TRIANGLE: return &seen_levels;
      S_IRQ:      return !irq_l;
      default:    return seen_level;
    endcase
  endfunction

  task automatic wait_for_goal(input int limit, input string what);
    int waited;
    waited = 0;
    while (!goal_reached() && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    assert (goal_reached())
      else begin
        $display("%s did not appear within %0d cycles", what, limit);
        abort_run();
      end
  endtask

  initial begin
    logic [3:0] vol;
    logic [1:0] duty;
    logic [7:0] period;
    rst        = 1'b1;
    cpu_clk_en = 1'b1;
    reg_addr   = '0;
    reg_data   = '0;
    reg_en     = 1'b0;
    reg_we     = 1'b0;
    section    = S_NONE;
    tone_level = '0;
    void'($urandom(75));
    repeat (2) @(posedge clk);
    rst     <= 1'b0;
    section <= S_RESET;
    idle_cycles(20);

    section <= S_DISABLED;
    write_reg(apu_pkg::FRAME_CTL, 8'h40);  // No IRQ until its own section.
    write_reg(apu_pkg::STATUS, 8'h00);
    write_pulse(apu_pkg::PULSE0_CTL, 2'($urandom_range(3, 0)), 1'b1,
                4'($urandom_range(15, 1)), 8'($urandom_range(15, 8)), 5'd1);
    write_pulse(apu_pkg::PULSE1_CTL, 2'($urandom_range(3, 0)), 1'b1,
                4'($urandom_range(15, 1)), 8'($urandom_range(15, 8)), 5'd1);
    idle_cycles(200);

    // Square tone on pulse0.
    vol        = 4'($urandom_range(15, 1));
    duty       = 2'($urandom_range(3, 0));
    period     = 8'($urandom_range(15, 8));
    tone_level <= PULSE_STEP * 16'(vol);
    section    <= S_TONE;
    write_reg(apu_pkg::STATUS, 8'h01);
    write_pulse(apu_pkg::PULSE0_CTL, duty, 1'b1, vol, period, 5'd1);
    wait_for_goal(400, "Pulse0 high and low levels");

    write_reg(apu_pkg::PULSE0_LO, 8'($urandom_range(7, 0)));  // Too short to sound.
    idle_cycles(2);
    section <= S_SHORT;
    idle_cycles(100);

    section <= S_IRQ;
    write_reg(apu_pkg::FRAME_CTL, 8'h00);
    wait_for_goal(5 * 48 * 4, "Low irq_l");
    write_reg(apu_pkg::FRAME_CTL, 8'h40);
    idle_cycles(2);
    section <= S_IRQ_OFF;
    idle_cycles(400);

    // Length index 3 runs out after a few half frames.
    vol        = 4'($urandom_range(15, 1));
    period     = 8'($urandom_range(15, 8));
    tone_level <= PULSE_STEP * 16'(vol);
    section    <= S_LENGTH;
    write_reg(apu_pkg::STATUS, 8'h01);
    write_pulse(apu_pkg::PULSE0_CTL, 2'd2, 1'b0, vol, period, 5'd3);
    idle_cycles((int'(LENGTH_TABLE[3]) + 1) * HALF_CYCLES + 2);
    assert (seen_level)
      else begin
        $display("Pulse0 never sounded before its length counter ran out");
        abort_run();
      end
    section <= S_EXPIRED;
    idle_cycles(200);

    section <= S_RETONE;
    write_pulse(apu_pkg::PULSE0_CTL, 2'd2, 1'b1, vol, period, 5'd3);
    wait_for_goal(400, "Pulse0 tone after a length reload");
    write_reg(apu_pkg::STATUS, 8'h00);
    idle_cycles(2);
    section <= S_CLEARED;
    idle_cycles(50);

    section <= S_TRIANGLE;
    write_reg(apu_pkg::STATUS, 8'h04);
    write_reg(apu_pkg::TRI_LINEAR, 8'hFF);
    write_reg(apu_pkg::TRI_LO, 8'($urandom_range(7, 0)));
    write_reg(apu_pkg::TRI_HI, {5'd1, 3'b000});
    wait_for_goal(2000, "Every triangle level");

    section <= S_DONE;
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
src/apu_pkg.sv
src/apu_registers.sv
src/frame_sequencer.sv
src/pulse_channel.sv
src/triangle_channel.sv
src/mixer.sv
src/apu.sv
tests/apu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module apu_tb \
  -o apu_sim

./obj_dir/apu_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "Simulation passed, see sim.log"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
